//--- hw/ramio_config.svh
/*
  build constants for the memory and I/O bridge
  I/O register addresses, word RAM depth and UART bit timing
*/
`ifndef RAMIO_CONFIG_SVH
`define RAMIO_CONFIG_SVH

// ------------------------------
// I/O map at the top of the address space
// ------------------------------
// lower nibble drives the LEDs, 0 is on
`define RAMIO_ADDR_LED 32'hffff_fffc
// reads all ones while the transmitter is idle
`define RAMIO_ADDR_UART_OUT 32'hffff_fff8
// reads all ones when nothing received, cleared by a read
`define RAMIO_ADDR_UART_IN 32'hffff_fff4

// word RAM depth in 32-bit words
`define RAMIO_RAM_WORDS 256

// clock cycles per serial bit, kept short in this build
`define RAMIO_UART_CLKS_PER_BIT 8

`endif

//--- hw/access_pkg.sv
/*
  access encodings of the request port
  size enum, sign bit of read_type, RAM word union
*/
package access_pkg;

  // write_type and read_type[1:0]
  typedef enum logic [1:0] {
    ACC_NONE = 2'b00,
    ACC_BYTE = 2'b01,
    ACC_HALF = 2'b10,
    ACC_WORD = 2'b11
  } access_size_e;

  // read_type[2] set means sign-extend the loaded value
  localparam int READ_SIGNED_BIT = 2;

  // one RAM word, addressed by byte lane or by half-word lane
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } ram_word_u;

endpackage

//--- hw/uart_pkg.sv
/*
  serial frame phases shared by transmitter and receiver
*/
package uart_pkg;

  // ------------------------------
  // 8N1 frame: start, 8 data bits, stop
  // ------------------------------
  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,
    PH_START = 2'd1,
    PH_DATA  = 2'd2,
    PH_STOP  = 2'd3
  } uart_phase_e;

endpackage

//--- hw/lane_align.sv
/*
  byte lane aligner between request port and word RAM
  write lane placement with byte mask, read lane select and extension
*/
`timescale 1ns/10ps

module lane_align import access_pkg::*; (
  input  logic [2:0]  read_type,
  input  logic [1:0]  write_type,
  input  logic [1:0]  byte_offset,
  input  logic [31:0] data_in,
  input  logic [31:0] ram_rdata,
  output logic [31:0] ram_wdata,
  output logic [3:0]  ram_byte_mask,
  output logic [31:0] aligned_rdata
);

  access_size_e wr_size;
  access_size_e rd_size;
  ram_word_u    wr_word;
  ram_word_u    rd_word;
  logic         rd_signed;

  assign wr_size   = access_size_e'(write_type);
  assign rd_size   = access_size_e'(read_type[1:0]);
  assign rd_signed = read_type[READ_SIGNED_BIT];
  assign rd_word   = ram_rdata;
  assign ram_wdata = wr_word;

  // ------------------------------
  // write side
  // ------------------------------
  always_comb begin
    wr_word       = '0;
    ram_byte_mask = 4'b0000;
    case (wr_size)
      ACC_BYTE: begin
        wr_word.bytes[byte_offset] = data_in[7:0];
        ram_byte_mask              = 4'b0001 << byte_offset;
      end
      ACC_HALF: begin
        // odd offsets leave the mask empty, nothing is written
        if (!byte_offset[0]) begin
          wr_word.halves[byte_offset[1]] = data_in[15:0];
          ram_byte_mask                  = byte_offset[1] ? 4'b1100 : 4'b0011;
        end
      end
      ACC_WORD: begin
        if (byte_offset == 2'b00) begin
          wr_word       = data_in;
          ram_byte_mask = 4'b1111;
        end
      end
      default: ;
    endcase
  end

  // ------------------------------
  // read side
  // ------------------------------
  always_comb begin
    aligned_rdata = '0;
    case (rd_size)
      ACC_BYTE: begin
        aligned_rdata = {{24{rd_signed & rd_word.bytes[byte_offset][7]}},
                         rd_word.bytes[byte_offset]};
      end
      ACC_HALF: begin
        // misaligned half reads return zero
        if (!byte_offset[0]) begin
          aligned_rdata = {{16{rd_signed & rd_word.halves[byte_offset[1]][15]}},
                           rd_word.halves[byte_offset[1]]};
        end
      end
      ACC_WORD: begin
        if (byte_offset == 2'b00) aligned_rdata = rd_word;
      end
      default: ;
    endcase
  end

endmodule

//--- hw/word_ram.sv
/*
  on-chip word RAM with per-byte write enables
  registered read, ready while the word address is held
*/
`timescale 1ns/10ps
`include "ramio_config.svh"

module word_ram import access_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 enable,
  input  logic [$clog2(`RAMIO_RAM_WORDS)-1:0] word_addr,
  input  logic [3:0]                           byte_mask,
  input  logic [31:0]                          wdata,
  output logic [31:0]                          rdata,
  output logic                                 ready
);

  localparam int ADDR_W = $clog2(`RAMIO_RAM_WORDS);

  ram_word_u         mem [`RAMIO_RAM_WORDS];
  ram_word_u         wr_word;
  logic [ADDR_W-1:0] addr_q;
  logic              valid_q;

  assign wr_word = wdata;

  // storage and read register
  always_ff @(posedge clk) begin
    if (enable) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_mask[i]) mem[word_addr].bytes[i] <= wr_word.bytes[i];
      end
      // old contents on a write cycle, valid_q stays low then
      rdata  <= mem[word_addr];
      addr_q <= word_addr;
    end
  end

  // only a non-writing access leaves a usable read word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= enable && (byte_mask == 4'b0000);
    end
  end

  // drops at once when the requester moves to another word
  assign ready = valid_q && (addr_q == word_addr);

endmodule

//--- hw/uart_tx.sv
/*
  8N1 serial transmitter
  go/bsy level handshake, LSB first
*/
`timescale 1ns/10ps
`include "ramio_config.svh"

module uart_tx import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  logic [7:0] data,
  output logic       tx,
  output logic       bsy
);

  localparam int CPB   = `RAMIO_UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB + 1);

  uart_phase_e      phase;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shift;
  logic             ack_wait;
  logic             bit_end;

  assign bit_end = (clk_cnt == CNT_W'(CPB - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase    <= PH_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
      bsy      <= 1'b0;
      ack_wait <= 1'b0;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (phase)
        PH_IDLE: begin
          clk_cnt <= '0;
          // a finished frame needs go low before the next one
          if (!go) begin
            ack_wait <= 1'b0;
          end else if (!ack_wait) begin
            shift <= data;
            tx    <= 1'b0;
            bsy   <= 1'b1;
            phase <= PH_START;
          end
        end
        PH_START: begin
          if (bit_end) begin
            tx      <= shift[0];
            shift   <= shift >> 1;
            bit_cnt <= '0;
            phase   <= PH_DATA;
          end
        end
        PH_DATA: begin
          if (bit_end) begin
            if (bit_cnt == 3'd7) begin
              // stop bit
              tx    <= 1'b1;
              phase <= PH_STOP;
            end else begin
              tx      <= shift[0];
              shift   <= shift >> 1;
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        PH_STOP: begin
          if (bit_end) begin
            bsy      <= 1'b0;
            ack_wait <= 1'b1;
            phase    <= PH_IDLE;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

endmodule

//--- hw/uart_rx.sv
/*
  8N1 serial receiver
  two-flop input sync, mid-bit sampling, go/data_ready handshake
*/
`timescale 1ns/10ps
`include "ramio_config.svh"

module uart_rx import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int CPB   = `RAMIO_UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB + 1);

  uart_phase_e      phase;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             bit_end;
  logic             half_end;

  assign bit_end  = (clk_cnt == CNT_W'(CPB - 1));
  assign half_end = (clk_cnt == CNT_W'(CPB / 2 - 1));

  // line idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase      <= PH_IDLE;
      clk_cnt    <= '0;
      bit_cnt    <= '0;
      data_ready <= 1'b0;
    end else if (!go) begin
      // acknowledge, restart hunting for a start edge
      phase      <= PH_IDLE;
      clk_cnt    <= '0;
      data_ready <= 1'b0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
      case (phase)
        PH_IDLE: begin
          clk_cnt <= '0;
          if (!data_ready && rx_prev && !rx_sync) phase <= PH_START;
        end
        PH_START: begin
          // middle of start bit, a glitch sends us back to idle
          if (half_end) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            phase   <= rx_sync ? PH_IDLE : PH_DATA;
          end
        end
        PH_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            data    <= {rx_sync, data[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) phase <= PH_STOP;
          end
        end
        PH_STOP: begin
          if (bit_end) begin
            // framing error drops the byte
            data_ready <= rx_sync;
            phase      <= PH_IDLE;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

endmodule

//--- hw/ramio_ctrl.sv
/*
  request decoder and I/O registers
  LED register, UART status words and go acknowledges, read mux
*/
`timescale 1ns/10ps
`include "ramio_config.svh"

module ramio_ctrl import access_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  logic [2:0]  read_type,
  input  logic [1:0]  write_type,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  input  logic [31:0] aligned_rdata,
  input  logic        ram_ready,
  input  logic        tx_bsy,
  input  logic [7:0]  rx_byte,
  input  logic        rx_ready,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        ram_enable,
  output logic [3:0]  led,
  output logic        tx_go,
  output logic [7:0]  tx_byte,
  output logic        rx_go
);

  logic        is_led;
  logic        is_uart_out;
  logic        is_uart_in;
  logic        is_io;
  logic        wr_req;
  logic        rd_req;
  logic [31:0] tx_word;
  logic [31:0] rx_word;
  logic        tx_guard;

  // ------------------------------
  // address decode
  // ------------------------------
  assign is_led      = (address == `RAMIO_ADDR_LED);
  assign is_uart_out = (address == `RAMIO_ADDR_UART_OUT);
  assign is_uart_in  = (address == `RAMIO_ADDR_UART_IN);
  assign is_io       = is_led || is_uart_out || is_uart_in;

  assign wr_req = enable && (access_size_e'(write_type) != ACC_NONE);
  assign rd_req = enable && (access_size_e'(read_type[1:0]) != ACC_NONE);

  // I/O answers in the same cycle, RAM answers through its own ready
  assign ram_enable     = enable && !is_io;
  assign data_out_ready = is_io ? 1'b1 : ram_ready;

  // transmitter samples the low byte only at frame start
  assign tx_byte = tx_word[7:0];

  // read mux
  always_comb begin
    if (is_led)           data_out = {28'b0, led};
    else if (is_uart_out) data_out = tx_word;
    else if (is_uart_in)  data_out = rx_word;
    else                  data_out = aligned_rdata;
  end

  // ------------------------------
  // I/O registers and handshakes
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led      <= 4'hf;
      tx_word  <= '1;
      tx_go    <= 1'b0;
      tx_guard <= 1'b0;
      rx_word  <= '1;
      rx_go    <= 1'b1;
    end else begin
      tx_guard <= 1'b0;

      // a read of UART_IN consumes the word
      if (rd_req && is_uart_in) begin
        rx_word <= '1;
      end else if (rx_go && rx_ready) begin
        // overwrites a byte nobody read
        rx_word <= {24'b0, rx_byte};
        rx_go   <= 1'b0;
      end

      // one cycle low is the receiver acknowledge
      if (!rx_go) rx_go <= 1'b1;

      // frame done, bsy cannot be trusted in the cycle after raising go
      if (tx_go && !tx_bsy && !tx_guard) begin
        tx_go   <= 1'b0;
        tx_word <= '1;
      end

      // a write while busy only replaces the status word
      if (wr_req && is_uart_out) begin
        tx_word  <= {24'b0, data_in[7:0]};
        tx_go    <= 1'b1;
        tx_guard <= 1'b1;
      end

      if (wr_req && is_led) led <= data_in[3:0];
    end
  end

endmodule

//--- hw/ramio_top.sv
/*
  bridge top level
  control module, lane aligner, word RAM, UART pair
*/
`timescale 1ns/10ps
`include "ramio_config.svh"

module ramio_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  logic [2:0]  read_type,
  input  logic [1:0]  write_type,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  input  logic        uart_rx,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic [3:0]  led,
  output logic        uart_tx
);

  localparam int ADDR_W = $clog2(`RAMIO_RAM_WORDS);

  logic        ram_enable;
  logic [31:0] ram_wdata;
  logic [3:0]  ram_byte_mask;
  logic [31:0] ram_rdata;
  logic        ram_ready;
  logic [31:0] aligned_rdata;
  logic        tx_go;
  logic [7:0]  tx_byte;
  logic        tx_bsy;
  logic        rx_go;
  logic [7:0]  rx_byte;
  logic        rx_ready;

  ramio_ctrl ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .aligned_rdata  (aligned_rdata),
    .ram_ready      (ram_ready),
    .tx_bsy         (tx_bsy),
    .rx_byte        (rx_byte),
    .rx_ready       (rx_ready),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .ram_enable     (ram_enable),
    .led            (led),
    .tx_go          (tx_go),
    .tx_byte        (tx_byte),
    .rx_go          (rx_go)
  );

  // byte offset within the word selects the lane
  lane_align align_i (
    .read_type     (read_type),
    .write_type    (write_type),
    .byte_offset   (address[1:0]),
    .data_in       (data_in),
    .ram_rdata     (ram_rdata),
    .ram_wdata     (ram_wdata),
    .ram_byte_mask (ram_byte_mask),
    .aligned_rdata (aligned_rdata)
  );

  // word address, upper bits alias
  word_ram ram_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (ram_enable),
    .word_addr (address[ADDR_W+1:2]),
    .byte_mask (ram_byte_mask),
    .wdata     (ram_wdata),
    .rdata     (ram_rdata),
    .ready     (ram_ready)
  );

  uart_tx tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (tx_go),
    .data  (tx_byte),
    .tx    (uart_tx),
    .bsy   (tx_bsy)
  );

  uart_rx rx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_byte),
    .data_ready (rx_ready)
  );

endmodule

//--- sim/ramio_tb.sv
/*
  directed testbench for the memory and I/O bridge
  clock and reset, serial loopback, reference word model, test tasks
*/
`timescale 1ns/10ps
`include "ramio_config.svh"

module ramio_tb import access_pkg::*;;

  localparam int READ_TIMEOUT = 16;
  localparam int UART_TIMEOUT = 12 * 10 * `RAMIO_UART_CLKS_PER_BIT;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [2:0]  read_type;
  logic [1:0]  write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic [3:0]  led;
  logic        serial_tx;
  logic        serial_rx;

  logic [31:0] ref_mem [`RAMIO_RAM_WORDS];
  int          errors;
  int          tests_run;
  int          tests_failed;

  // X before reset counts as an idle line
  assign serial_rx = (serial_tx === 1'b0) ? 1'b0 : 1'b1;

  ramio_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .uart_rx        (serial_rx),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .led            (led),
    .uart_tx        (serial_tx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // reference model of the word RAM
  // ------------------------------
  function automatic void model_write(input logic [31:0] addr, input logic [1:0] wtype,
                                      input logic [31:0] data);
    int          idx;
    int          off;
    logic [31:0] w;
    idx = (addr >> 2) % `RAMIO_RAM_WORDS;
    off = addr[1:0];
    w   = ref_mem[idx];
    case (access_size_e'(wtype))
      ACC_BYTE: w[off*8 +: 8] = data[7:0];
      ACC_HALF: if (off % 2 == 0) w[off*8 +: 16] = data[15:0];
      ACC_WORD: if (off == 0) w = data;
      default: ;
    endcase
    ref_mem[idx] = w;
  endfunction

  // lane select plus sign or zero fill, misaligned gives zero
  function automatic logic [31:0] expect_read(input logic [31:0] word, input logic [1:0] off,
                                              input logic [2:0] rtype);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[off*8 +: 8];
    h = word[off[1]*16 +: 16];
    case (access_size_e'(rtype[1:0]))
      ACC_BYTE: return rtype[2] ? {{24{b[7]}}, b} : {24'h0, b};
      ACC_HALF: begin
        if (off[0]) return 32'h0;
        return rtype[2] ? {{16{h[15]}}, h} : {16'h0, h};
      end
      ACC_WORD: return (off == 2'b00) ? word : 32'h0;
      default:  return 32'h0;
    endcase
  endfunction

  // ------------------------------
  // bus tasks
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // inputs held until data_out_ready, sampled on the falling edge
  task automatic bus_read(input logic [31:0] addr, input logic [2:0] rtype,
                          output logic [31:0] data, output int wait_cycles);
    @(posedge clk);
    enable     <= 1'b1;
    read_type  <= rtype;
    write_type <= ACC_NONE;
    address    <= addr;
    wait_cycles = 0;
    @(negedge clk);
    while (!data_out_ready && wait_cycles < READ_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    assert (data_out_ready) else begin
      $display("no data_out_ready for a read of address %h", addr);
      errors++;
    end
    data = data_out;
    @(posedge clk);
    enable    <= 1'b0;
    read_type <= 3'b000;
  endtask

  // a write lasts one cycle and has no handshake
  task automatic bus_write(input logic [31:0] addr, input logic [1:0] wtype,
                           input logic [31:0] data);
    @(posedge clk);
    enable     <= 1'b1;
    write_type <= wtype;
    read_type  <= 3'b000;
    address    <= addr;
    data_in    <= data;
    @(posedge clk);
    enable     <= 1'b0;
    write_type <= ACC_NONE;
  endtask

  task automatic ram_write(input logic [31:0] addr, input logic [1:0] wtype,
                           input logic [31:0] data);
    bus_write(addr, wtype, data);
    model_write(addr, wtype, data);
  endtask

  task automatic report_test(input int num, input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_defaults();
    int          e0;
    int          w;
    logic [31:0] got;
    e0 = errors;
    @(negedge clk);
    check_value("led", {28'h0, led}, 32'hf);
    bus_read(`RAMIO_ADDR_LED, {1'b0, ACC_WORD}, got, w);
    check_value("data_out led", got, 32'h0000_000f);
    bus_read(`RAMIO_ADDR_UART_OUT, {1'b0, ACC_WORD}, got, w);
    check_value("data_out uart_out", got, 32'hffff_ffff);
    check_value("wait cycles uart_out", w, 0);
    bus_read(`RAMIO_ADDR_UART_IN, {1'b0, ACC_WORD}, got, w);
    check_value("data_out uart_in", got, 32'hffff_ffff);
    check_value("wait cycles uart_in", w, 0);
    report_test(1, "reset state", e0);
  endtask

  task automatic word_round_trip();
    int          e0;
    int          w;
    logic [31:0] addrs [16];
    logic [31:0] got;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = ($urandom() % `RAMIO_RAM_WORDS) << 2;
      ram_write(addrs[i], ACC_WORD, $urandom());
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(addrs[i], {1'b0, ACC_WORD}, got, w);
      check_value("data_out word", got, ref_mem[(addrs[i] >> 2) % `RAMIO_RAM_WORDS]);
    end
    report_test(2, "word write and read", e0);
  endtask

  task automatic sub_word_merge();
    int          e0;
    int          w;
    logic [31:0] base;
    logic [31:0] rnd;
    logic [31:0] got;
    logic [31:0] word;
    logic [2:0]  rtype;
    e0   = errors;
    base = 32'h0000_0100;
    ram_write(base, ACC_WORD, 32'h1122_3344);
    // upper data bits are noise, only the low lanes may land
    rnd = $urandom();
    ram_write(base + 1, ACC_BYTE, {rnd[31:8], 8'ha5});
    rnd = $urandom();
    ram_write(base + 2, ACC_HALF, {rnd[31:16], 16'hc3e7});
    // odd half write must leave the word alone
    ram_write(base + 3, ACC_HALF, 32'h0000_beef);
    word = ref_mem[(base >> 2) % `RAMIO_RAM_WORDS];
    bus_read(base, {1'b0, ACC_WORD}, got, w);
    check_value("data_out merged word", got, word);
    for (int off = 0; off < 4; off++) begin
      for (int sgn = 0; sgn < 2; sgn++) begin
        rtype = {sgn[0], ACC_BYTE};
        bus_read(base + off, rtype, got, w);
        check_value("data_out byte", got, expect_read(word, off[1:0], rtype));
        if (off % 2 == 0) begin
          rtype = {sgn[0], ACC_HALF};
          bus_read(base + off, rtype, got, w);
          check_value("data_out half", got, expect_read(word, off[1:0], rtype));
        end
      end
    end
    bus_read(base + 1, {1'b1, ACC_HALF}, got, w);
    check_value("data_out misaligned half", got, 32'h0);
    report_test(3, "byte and half access", e0);
  endtask

  task automatic led_register();
    int          e0;
    int          w;
    logic [31:0] addr;
    logic [31:0] got;
    e0   = errors;
    // ordinary address on the RAM word that the LED address aliases to
    addr = `RAMIO_ADDR_LED % (`RAMIO_RAM_WORDS * 4);
    ram_write(addr, ACC_WORD, 32'h0bad_cafe);
    bus_write(`RAMIO_ADDR_LED, ACC_WORD, 32'h0000_0005);
    @(negedge clk);
    check_value("led", {28'h0, led}, 32'h5);
    bus_read(`RAMIO_ADDR_LED, {1'b0, ACC_WORD}, got, w);
    check_value("data_out led", got, 32'h0000_0005);
    bus_read(addr, {1'b0, ACC_WORD}, got, w);
    check_value("data_out after led write", got, ref_mem[(addr >> 2) % `RAMIO_RAM_WORDS]);
    report_test(4, "led register", e0);
  endtask

  task automatic uart_loopback();
    int          e0;
    int          w;
    int          cycles;
    logic [31:0] rnd;
    logic [31:0] got;
    e0  = errors;
    rnd = $urandom();
    bus_write(`RAMIO_ADDR_UART_OUT, ACC_WORD, {rnd[31:8], 8'h5a});
    bus_read(`RAMIO_ADDR_UART_OUT, {1'b0, ACC_WORD}, got, w);
    check_value("data_out uart_out busy", got, 32'h0000_005a);
    // poll the status word until the frame is out
    cycles = 0;
    while (got !== 32'hffff_ffff && cycles < UART_TIMEOUT) begin
      bus_read(`RAMIO_ADDR_UART_OUT, {1'b0, ACC_WORD}, got, w);
      cycles += 2 + w;
    end
    assert (got === 32'hffff_ffff) else begin
      $display("UART_OUT did not return to idle within 12 frames");
      errors++;
    end
    bus_read(`RAMIO_ADDR_UART_IN, {1'b0, ACC_WORD}, got, w);
    check_value("data_out uart_in byte", got, 32'h0000_005a);
    bus_read(`RAMIO_ADDR_UART_IN, {1'b0, ACC_WORD}, got, w);
    check_value("data_out uart_in empty", got, 32'hffff_ffff);
    report_test(5, "uart loopback", e0);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'heaed5628));
    rst_n        = 1'b0;
    enable       = 1'b0;
    read_type    = 3'b000;
    write_type   = 2'b00;
    address      = 32'h0;
    data_in      = 32'h0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    reset_defaults();
    word_round_trip();
    sub_word_merge();
    led_register();
    uart_loopback();
    $display("summary: %0d tests run, %0d tests failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+hw
hw/access_pkg.sv
hw/uart_pkg.sv
hw/lane_align.sv
hw/word_ram.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/ramio_ctrl.sv
hw/ramio_top.sv
sim/ramio_tb.sv
